//--- files.f
+incdir+verification
hdl/csr_map_pkg.sv
hdl/csr_op_pkg.sv
hdl/csr_ifs.sv
hdl/csr_control.sv
hdl/csr_regfile.sv
hdl/csr_timer.sv
hdl/csr_top.sv
verification/csr_tb.sv

//--- hdl/csr_control.sv
module csr_control
    import csr_map_pkg::*;
    import csr_op_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       op_valid,
    input  csr_op_t                    op,
    input  logic [CSR_NUM_W-1:0]       csr_num,
    input  logic [DATA_W-1:0]          wdata,
    input  logic [DATA_W-1:0]          wmask,
    input  logic [DATA_W-1:0]          pc,
    input  logic                       excp_valid,
    input  ecode_t                     excp_ecode,
    input  logic [SUBCODE_W-1:0]       excp_subcode,
    input  logic [LIE_HW_HI:LIE_HW_LO] hw_int,
    input  logic                       ti_pending,
    input  logic                       crmd_ie,
    input  logic [INT_LINES-1:0]       ecfg_lie,
    input  logic [IS_SW_HI:IS_SW_LO]   estat_is,
    input  logic [DATA_W-1:0]          era,
    input  logic [DATA_W-1:0]          eentry,
    input  logic [DATA_W-1:0]          rdata_raw,
    output logic [DATA_W-1:0]          rdata,
    output logic                       flush,
    output logic [DATA_W-1:0]          redirect_pc,
    csr_commit_if.ctrl                 commit
);

    logic [INT_LINES-1:0] int_vec;
    logic                 trap_busy;
    logic                 int_req;
    logic                 nxt_valid;
    csr_op_t              nxt_op;
    ecode_t               nxt_ecode;
    logic [SUBCODE_W-1:0] nxt_subcode;
    logic [DATA_W-1:0]    wmask_eff;
    logic [DATA_W-1:0]    merged;
    logic [DATA_W-1:0]    nxt_redirect;

    always_comb
    begin
        int_vec = '0;     // bit 10 has no source
        int_vec[IS_SW_HI:IS_SW_LO]   = estat_is;
        int_vec[LIE_HW_HI:LIE_HW_LO] = hw_int;
        int_vec[LIE_TI]              = ti_pending;
    end

    // IE is only cleared when the trap commits
    assign trap_busy = commit.commit_valid && (commit.commit_op == TRAP);
    assign int_req   = crmd_ie && (|(int_vec & ecfg_lie)) && !trap_busy;

    always_comb
    begin
        nxt_valid   = 1'b0;
        nxt_op      = NOP;
        nxt_ecode   = INT;
        nxt_subcode = '0;
        if (int_req)
        begin
            nxt_valid = 1'b1;
            nxt_op    = TRAP;
        end
        else if (excp_valid)
        begin
            nxt_valid   = 1'b1;
            nxt_op      = TRAP;
            nxt_ecode   = excp_ecode;
            nxt_subcode = excp_subcode;
        end
        else if (op_valid && (op != NOP))
        begin
            nxt_valid = 1'b1;
            nxt_op    = op;
        end
    end

    assign wmask_eff = (nxt_op == CSRXCHG) ? wmask : '1;
    assign merged    = (rdata_raw & ~wmask_eff) | (wdata & wmask_eff);

    always_comb
    begin
        case (nxt_op)
            ERTN:    nxt_redirect = era;
            TRAP:    nxt_redirect = eentry;
            default: nxt_redirect = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            commit.commit_valid <= 1'b0;
            commit.commit_op    <= NOP;
            flush               <= 1'b0;
        end
        else
        begin
            commit.commit_valid <= nxt_valid;
            commit.commit_op    <= nxt_op;
            flush               <= nxt_valid && (nxt_op != CSRRD);
        end
    end

    always_ff @(posedge clk)
    begin
        commit.commit_num     <= csr_num;
        commit.commit_wdata   <= merged;
        commit.commit_pc      <= pc;
        commit.commit_ecode   <= nxt_ecode;
        commit.commit_subcode <= nxt_subcode;
        rdata                 <= rdata_raw;     // value before the op lands
        redirect_pc           <= nxt_redirect;
    end

    a_op_known: assert property (@(posedge clk) disable iff (!rstn)
        op_valid |-> !$isunknown(op))
        else $error("op unknown while op_valid");

endmodule

//--- hdl/csr_ifs.sv
interface csr_commit_if;
    logic                              commit_valid;
    csr_op_pkg::csr_op_t               commit_op;
    logic [csr_map_pkg::CSR_NUM_W-1:0] commit_num;
    logic [csr_map_pkg::DATA_W-1:0]    commit_wdata;    // mask already applied
    logic [csr_map_pkg::DATA_W-1:0]    commit_pc;
    csr_op_pkg::ecode_t                commit_ecode;
    logic [csr_map_pkg::SUBCODE_W-1:0] commit_subcode;

    modport ctrl (
        output commit_valid, commit_op, commit_num, commit_wdata,
        output commit_pc, commit_ecode, commit_subcode
    );

    modport regs (
        input commit_valid, commit_op, commit_num, commit_wdata,
        input commit_pc, commit_ecode, commit_subcode
    );
endinterface

interface csr_timer_if;
    logic                            tcfg_we;
    logic [csr_map_pkg::TIMER_W-1:0] tcfg_wdata;
    logic                            ti_clr;
    logic [csr_map_pkg::TIMER_W-1:0] tcfg;
    logic [csr_map_pkg::TIMER_W-1:0] tval;
    logic                            ti_pending;

    modport regs (output tcfg_we, tcfg_wdata, ti_clr, input tcfg, tval, ti_pending);

    modport timer (input tcfg_we, tcfg_wdata, ti_clr, output tcfg, tval, ti_pending);
endinterface

//--- hdl/csr_map_pkg.sv
package csr_map_pkg;

    localparam int DATA_W    = 32;
    localparam int CSR_NUM_W = 14;
    localparam int TIMER_W   = 32;
    localparam int INT_LINES = 12;
    localparam int SUBCODE_W = 9;
    localparam int EENTRY_LO = 6;     // entry point is 64 byte aligned

    typedef enum logic [CSR_NUM_W-1:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        EENTRY = 14'h00C,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TID    = 14'h040,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_addr_t;

    localparam logic [DATA_W-1:0] CRMD_RESET = 32'h0000_0008;   // DA set, PLV0, IE off

    // crmd
    localparam int PLV_IE_HI    = 2;
    localparam int PLV_IE_LO    = 0;
    localparam int DA_PG_HI     = 4;
    localparam int DA_PG_LO     = 3;
    localparam int DATF_DATM_HI = 8;
    localparam int DATF_DATM_LO = 5;

    // interrupt lines, same layout in ecfg and estat
    localparam int IS_SW_HI  = 1;
    localparam int IS_SW_LO  = 0;
    localparam int LIE_HW_HI = 9;
    localparam int LIE_HW_LO = 2;
    localparam int LIE_TI    = 11;

    localparam int ESTAT_ECODE_HI   = 21;
    localparam int ESTAT_ECODE_LO   = 16;
    localparam int ESTAT_SUBCODE_HI = 30;
    localparam int ESTAT_SUBCODE_LO = 22;

    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;

endpackage

//--- hdl/csr_op_pkg.sv
package csr_op_pkg;

    // encodings follow the pipeline subtype field
    typedef enum logic [3:0] {
        TRAP    = 4'h0,     // exception or interrupt entry
        ERTN    = 4'h6,
        CSRRD   = 4'h8,
        CSRWR   = 4'h9,
        CSRXCHG = 4'hA,
        NOP     = 4'hF
    } csr_op_t;

    typedef enum logic [5:0] {
        INT = 6'h00,
        ADE = 6'h08,        // address error
        ALE = 6'h09,        // misaligned access
        SYS = 6'h0B,
        BRK = 6'h0C,
        INE = 6'h0D         // undefined instruction
    } ecode_t;

endpackage

//--- hdl/csr_regfile.sv
module csr_regfile
    import csr_map_pkg::*;
    import csr_op_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [CSR_NUM_W-1:0]     rd_num,
    csr_commit_if.regs               commit,
    csr_timer_if.regs                timer,
    output logic [DATA_W-1:0]        rdata_raw,
    output logic [DATA_W-1:0]        crmd,
    output logic                     crmd_ie,
    output logic [INT_LINES-1:0]     ecfg_lie,
    output logic [IS_SW_HI:IS_SW_LO] estat_is,
    output logic [DATA_W-1:0]        era,
    output logic [DATA_W-1:0]        eentry,
    output logic                     excp_flush,
    output logic                     ertn_flush
);

    logic [DATF_DATM_HI:0]       crmd_q;
    logic [PLV_IE_HI:PLV_IE_LO]  prmd_q;
    logic [INT_LINES-1:0]        ecfg_lie_q;
    logic [IS_SW_HI:IS_SW_LO]    estat_sw_q;
    ecode_t                      estat_ecode_q;
    logic [SUBCODE_W-1:0]        estat_subcode_q;
    logic [DATA_W-1:0]           era_q;
    logic [DATA_W-1:EENTRY_LO]   eentry_q;
    logic [DATA_W-1:0]           save_q [0:3];
    logic [DATA_W-1:0]           tid_q;
    logic [DATA_W-1:0]           wd;
    logic                        wr_commit;

    assign wd        = commit.commit_wdata;
    assign wr_commit = commit.commit_valid &&
                       ((commit.commit_op == CSRWR) || (commit.commit_op == CSRXCHG));

    // timer side effects land with the commit edge
    assign timer.tcfg_we    = wr_commit && (commit.commit_num == TCFG);
    assign timer.tcfg_wdata = wd[TIMER_W-1:0];
    assign timer.ti_clr     = wr_commit && (commit.commit_num == TICLR) && wd[0];

    assign crmd     = {{(DATA_W-DATF_DATM_HI-1){1'b0}}, crmd_q};
    assign crmd_ie  = crmd_q[PLV_IE_HI];
    assign ecfg_lie = ecfg_lie_q;
    assign estat_is = estat_sw_q;
    assign era      = era_q;
    assign eentry   = {eentry_q, {EENTRY_LO{1'b0}}};

    always_comb
    begin
        rdata_raw = '0;     // unknown numbers read zero
        case (rd_num)
            CRMD:   rdata_raw[DATF_DATM_HI:0] = crmd_q;
            PRMD:   rdata_raw[PLV_IE_HI:PLV_IE_LO] = prmd_q;
            ECFG:   rdata_raw[INT_LINES-1:0] = ecfg_lie_q;
            ESTAT:
            begin
                rdata_raw[IS_SW_HI:IS_SW_LO]                 = estat_sw_q;
                rdata_raw[LIE_TI]                            = timer.ti_pending;
                rdata_raw[ESTAT_ECODE_HI:ESTAT_ECODE_LO]     = estat_ecode_q;
                rdata_raw[ESTAT_SUBCODE_HI:ESTAT_SUBCODE_LO] = estat_subcode_q;
            end
            ERA:    rdata_raw = era_q;
            EENTRY: rdata_raw = eentry;
            SAVE0, SAVE1, SAVE2, SAVE3:
                    rdata_raw = save_q[rd_num[1:0]];
            TID:    rdata_raw = tid_q;
            TCFG:   rdata_raw[TIMER_W-1:0] = timer.tcfg;
            TVAL:   rdata_raw[TIMER_W-1:0] = timer.tval;
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q          <= CRMD_RESET[DATF_DATM_HI:0];
            prmd_q          <= '0;
            ecfg_lie_q      <= '0;
            estat_sw_q      <= '0;
            estat_ecode_q   <= INT;
            estat_subcode_q <= '0;
            era_q           <= '0;
            eentry_q        <= '0;
            save_q          <= '{default: '0};
            tid_q           <= '0;
            excp_flush      <= 1'b0;
            ertn_flush      <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            if (commit.commit_valid)
            begin
                case (commit.commit_op)
                    TRAP:
                    begin
                        prmd_q                      <= crmd_q[PLV_IE_HI:PLV_IE_LO];
                        crmd_q[PLV_IE_HI:PLV_IE_LO] <= '0;     // kernel, irq off
                        era_q                       <= commit.commit_pc;
                        estat_ecode_q               <= commit.commit_ecode;
                        estat_subcode_q             <= commit.commit_subcode;
                        excp_flush                  <= 1'b1;
                    end
                    ERTN:
                    begin
                        crmd_q[PLV_IE_HI:PLV_IE_LO] <= prmd_q;
                        ertn_flush                  <= 1'b1;
                    end
                    CSRWR, CSRXCHG:
                    begin
                        case (commit.commit_num)
                            CRMD:
                            begin
                                crmd_q[PLV_IE_HI:PLV_IE_LO] <= wd[PLV_IE_HI:PLV_IE_LO];
                                crmd_q[DATF_DATM_HI:DATF_DATM_LO] <=
                                    wd[DATF_DATM_HI:DATF_DATM_LO];
                                // DA and PG may not both be set or both clear
                                if (wd[DA_PG_HI] ^ wd[DA_PG_LO])
                                    crmd_q[DA_PG_HI:DA_PG_LO] <= wd[DA_PG_HI:DA_PG_LO];
                            end
                            PRMD:   prmd_q <= wd[PLV_IE_HI:PLV_IE_LO];
                            ECFG:
                            begin
                                ecfg_lie_q[LIE_TI]             <= wd[LIE_TI];
                                ecfg_lie_q[LIE_HW_HI:IS_SW_LO] <= wd[LIE_HW_HI:IS_SW_LO];
                            end
                            ESTAT:  estat_sw_q <= wd[IS_SW_HI:IS_SW_LO];   // sw bits only
                            ERA:    era_q <= wd;
                            EENTRY: eentry_q <= wd[DATA_W-1:EENTRY_LO];
                            SAVE0, SAVE1, SAVE2, SAVE3:
                                    save_q[commit.commit_num[1:0]] <= wd;
                            TID:    tid_q <= wd;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    a_commit_op_legal: assert property (@(posedge clk) disable iff (!rstn)
        commit.commit_valid |-> (commit.commit_op inside {TRAP, ERTN, CSRRD, CSRWR, CSRXCHG}))
        else $error("illegal op committed");

endmodule

//--- hdl/csr_timer.sv
module csr_timer
    import csr_map_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    csr_timer_if.timer timer
);

    logic [TIMER_W-1:0] tcfg_q;
    logic [TIMER_W-1:0] tval_q;
    logic               wr_pending;     // tcfg written last cycle
    logic               ti_pending_q;
    logic               en;
    logic [TIMER_W-1:0] init_val;

    assign en       = tcfg_q[TCFG_EN];
    assign init_val = {tcfg_q[TIMER_W-1:TCFG_PERIODIC+1], 2'b00};

    assign timer.tcfg       = tcfg_q;
    assign timer.tval       = en ? tval_q : '0;
    assign timer.ti_pending = ti_pending_q;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg_q       <= '0;
            tval_q       <= '0;
            wr_pending   <= 1'b0;
            ti_pending_q <= 1'b0;
        end
        else
        begin
            wr_pending <= timer.tcfg_we;
            if (timer.tcfg_we)
                tcfg_q <= timer.tcfg_wdata;

            if (timer.ti_clr)
                ti_pending_q <= 1'b0;
            else if (en && !wr_pending && (tval_q == '0))
                ti_pending_q <= 1'b1;

            if (en)
            begin
                if (wr_pending || ((tval_q == '0) && tcfg_q[TCFG_PERIODIC]))
                    tval_q <= init_val;
                else if (tval_q != '1)
                    tval_q <= tval_q - 1'b1;   // one-shot parks at all ones
            end
        end
    end

    a_tcfg_known: assert property (@(posedge clk) disable iff (!rstn)
        timer.tcfg_we |-> !$isunknown(timer.tcfg_wdata))
        else $error("tcfg written with unknown data");

endmodule

//--- hdl/csr_top.sv
module csr_top
    import csr_map_pkg::*;
    import csr_op_pkg::*;
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           op_valid,
    input  csr_op_t                        op,
    input  logic [CSR_NUM_W-1:0]           csr_num,
    input  logic [DATA_W-1:0]              wdata,
    input  logic [DATA_W-1:0]              wmask,
    input  logic [DATA_W-1:0]              pc,
    input  logic                           excp_valid,
    input  ecode_t                         excp_ecode,
    input  logic [SUBCODE_W-1:0]           excp_subcode,
    input  logic [LIE_HW_HI-LIE_HW_LO:0]   hw_int,
    output logic [DATA_W-1:0]              rdata,
    output logic                           flush,
    output logic [DATA_W-1:0]              redirect_pc,
    output logic                           excp_flush,
    output logic                           ertn_flush,
    output logic [DATA_W-1:0]              crmd
);

    logic [DATA_W-1:0]        rdata_raw;
    logic                     crmd_ie;
    logic [INT_LINES-1:0]     ecfg_lie;
    logic [IS_SW_HI:IS_SW_LO] estat_is;
    logic [DATA_W-1:0]        era;
    logic [DATA_W-1:0]        eentry;

    csr_commit_if commit_bus ();
    csr_timer_if  timer_bus ();

    csr_control control_inst (
        .clk          (clk),
        .rstn         (rstn),
        .op_valid     (op_valid),
        .op           (op),
        .csr_num      (csr_num),
        .wdata        (wdata),
        .wmask        (wmask),
        .pc           (pc),
        .excp_valid   (excp_valid),
        .excp_ecode   (excp_ecode),
        .excp_subcode (excp_subcode),
        .hw_int       (hw_int),
        .ti_pending   (timer_bus.ti_pending),
        .crmd_ie      (crmd_ie),
        .ecfg_lie     (ecfg_lie),
        .estat_is     (estat_is),
        .era          (era),
        .eentry       (eentry),
        .rdata_raw    (rdata_raw),
        .rdata        (rdata),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .commit       (commit_bus.ctrl)
    );

    csr_regfile regfile_inst (
        .clk        (clk),
        .rstn       (rstn),
        .rd_num     (csr_num),
        .commit     (commit_bus.regs),
        .timer      (timer_bus.regs),
        .rdata_raw  (rdata_raw),
        .crmd       (crmd),
        .crmd_ie    (crmd_ie),
        .ecfg_lie   (ecfg_lie),
        .estat_is   (estat_is),
        .era        (era),
        .eentry     (eentry),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    csr_timer timer_inst (
        .clk   (clk),
        .rstn  (rstn),
        .timer (timer_bus.timer)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the csr testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module csr_tb -Mdir obj_dir -o csr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/csr_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verification/csr_ref.svh
`ifndef CSR_REF_SVH
`define CSR_REF_SVH

function automatic logic [DATA_W-1:0] ref_merge(input logic [DATA_W-1:0] old,
                                                input logic [DATA_W-1:0] wd,
                                                input logic [DATA_W-1:0] mask);
    logic [DATA_W-1:0] res;
    for (int b = 0; b < DATA_W; b++)
        res[b] = mask[b] ? wd[b] : old[b];     // set mask bit takes the new data
    return res;
endfunction

// DA/PG only move when the written pair is 01 or 10
function automatic logic [DATA_W-1:0] ref_crmd_write(input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] wd);
    logic [DATA_W-1:0] res;
    res = '0;
    res[PLV_IE_HI:PLV_IE_LO]       = wd[PLV_IE_HI:PLV_IE_LO];
    res[DATF_DATM_HI:DATF_DATM_LO] = wd[DATF_DATM_HI:DATF_DATM_LO];
    if (wd[DA_PG_HI] != wd[DA_PG_LO])
        res[DA_PG_HI:DA_PG_LO] = wd[DA_PG_HI:DA_PG_LO];
    else
        res[DA_PG_HI:DA_PG_LO] = old[DA_PG_HI:DA_PG_LO];
    return res;
endfunction

function automatic logic [DATA_W-1:0] ref_redirect(input csr_op_t kind,
                                                   input logic [DATA_W-1:0] pc_val,
                                                   input logic [DATA_W-1:0] era_val,
                                                   input logic [DATA_W-1:0] eentry_val);
    case (kind)
        ERTN:    return era_val;
        TRAP:    return eentry_val & ~32'h0000_003f;   // 64 byte aligned entry
        default: return pc_val + 32'd4;
    endcase
endfunction

// value read back after a full write to one of the plain storage registers
function automatic logic [DATA_W-1:0] ref_readback(input logic [CSR_NUM_W-1:0] num,
                                                   input logic [DATA_W-1:0] wd);
    case (num)
        EENTRY:                          return wd & ~32'h0000_003f;
        SAVE0, SAVE1, SAVE2, SAVE3, TID: return wd;
        default:                         return '0;
    endcase
endfunction

function automatic logic [DATA_W-1:0] ref_estat(input logic [1:0] sw, input logic ti,
                                                input ecode_t code,
                                                input logic [SUBCODE_W-1:0] sub);
    logic [DATA_W-1:0] res;
    res = '0;
    res[IS_SW_HI:IS_SW_LO]                 = sw;
    res[LIE_TI]                            = ti;
    res[ESTAT_ECODE_HI:ESTAT_ECODE_LO]     = code;
    res[ESTAT_SUBCODE_HI:ESTAT_SUBCODE_LO] = sub;
    return res;
endfunction

`endif

//--- verification/csr_tb.sv
module csr_tb
    import csr_map_pkg::*;
    import csr_op_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [7:0] DA_PG_SEQ = 8'b10_01_11_00;     // 00, 11, 01, 10

    logic                           clk;
    logic                           rstn;
    logic                           op_valid;
    csr_op_t                        op;
    logic [CSR_NUM_W-1:0]           csr_num;
    logic [DATA_W-1:0]              wdata;
    logic [DATA_W-1:0]              wmask;
    logic [DATA_W-1:0]              pc;
    logic                           excp_valid;
    ecode_t                         excp_ecode;
    logic [SUBCODE_W-1:0]           excp_subcode;
    logic [LIE_HW_HI-LIE_HW_LO:0]   hw_int;
    logic [DATA_W-1:0]              rdata;
    logic                           flush;
    logic [DATA_W-1:0]              redirect_pc;
    logic                           excp_flush;
    logic                           ertn_flush;
    logic [DATA_W-1:0]              crmd;

    integer            seed;
    int                check_count;
    int                error_count;
    int                timeout_count;
    logic [DATA_W-1:0] exp_rdata_q [$];
    bit                exp_chk_rd_q [$];
    bit                exp_flush_q [$];
    logic [DATA_W-1:0] exp_redir_q [$];

    // expected architectural state
    logic [DATA_W-1:0] save_exp [0:3];
    logic [DATA_W-1:0] tid_exp;
    logic [DATA_W-1:0] eentry_exp;
    logic [DATA_W-1:0] ecfg_exp;
    logic [DATA_W-1:0] crmd_exp;
    logic [DATA_W-1:0] prmd_exp;
    logic [DATA_W-1:0] era_exp;
    logic [DATA_W-1:0] estat_exp;
    logic [DATA_W-1:0] last_pc;

    `include "csr_ref.svh"

    csr_top csr_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .op_valid     (op_valid),
        .op           (op),
        .csr_num      (csr_num),
        .wdata        (wdata),
        .wmask        (wmask),
        .pc           (pc),
        .excp_valid   (excp_valid),
        .excp_ecode   (excp_ecode),
        .excp_subcode (excp_subcode),
        .hw_int       (hw_int),
        .rdata        (rdata),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .excp_flush   (excp_flush),
        .ertn_flush   (ertn_flush),
        .crmd         (crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // issue results are valid for the one cycle after the issue edge
    always @(negedge clk)
    begin : compare_issue
        logic [DATA_W-1:0] want_rdata;
        logic [DATA_W-1:0] want_redirect;
        bit                want_flush;
        bit                chk_rdata;
        if (exp_flush_q.size() > 0)
        begin
            want_rdata    = exp_rdata_q.pop_front();
            chk_rdata     = exp_chk_rd_q.pop_front();
            want_flush    = exp_flush_q.pop_front();
            want_redirect = exp_redir_q.pop_front();
            if (chk_rdata)
                check_value("rdata", rdata, want_rdata);
            check_value("flush", flush, want_flush);
            if (want_flush)
                check_value("redirect_pc", redirect_pc, want_redirect);
        end
    end

    task automatic issue_op(input csr_op_t kind, input logic [CSR_NUM_W-1:0] num,
                            input logic [DATA_W-1:0] wd, input logic [DATA_W-1:0] wm,
                            input logic [DATA_W-1:0] old, input bit chk_rd);
        logic [DATA_W-1:0] pc_val;
        pc_val = $random(seed);
        pc_val[1:0] = 2'b00;
        last_pc = pc_val;
        @(posedge clk);
        op_valid <= 1'b1;
        op       <= kind;
        csr_num  <= num;
        wdata    <= wd;
        wmask    <= wm;
        pc       <= pc_val;
        @(posedge clk);     // issue edge
        op_valid <= 1'b0;
        exp_rdata_q.push_back(old);
        exp_chk_rd_q.push_back(chk_rd);
        exp_flush_q.push_back(kind != CSRRD);
        exp_redir_q.push_back(ref_redirect(kind, pc_val, era_exp, eentry_exp));
        @(posedge clk);     // commit edge
    endtask

    task automatic write_csr(input logic [CSR_NUM_W-1:0] num, input logic [DATA_W-1:0] wd,
                             input logic [DATA_W-1:0] old);
        issue_op(CSRWR, num, wd, $random(seed), old, 1'b1);    // mask must be ignored
    endtask

    task automatic read_csr(input logic [CSR_NUM_W-1:0] num, input logic [DATA_W-1:0] want);
        issue_op(CSRRD, num, '0, '0, want, 1'b1);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            check_value("flush", flush, 1'b0);
            check_value("excp_flush", excp_flush, 1'b0);
            check_value("ertn_flush", ertn_flush, 1'b0);
        end
    endtask

    task automatic verify_crmd();
        @(negedge clk);
        check_value("crmd", crmd, crmd_exp);
    endtask

    task automatic wait_trap(input int limit, input string what);
        int n;
        bit seen_flush;
        bit done;
        n = 0;
        seen_flush = 1'b0;
        done = 1'b0;
        while (!done && n < limit)
        begin
            @(negedge clk);
            n++;
            if (flush && !seen_flush)
            begin
                seen_flush = 1'b1;
                check_value("redirect_pc", redirect_pc,
                            ref_redirect(TRAP, '0, era_exp, eentry_exp));
            end
            done = (excp_flush === 1'b1);
        end
        if (!done)
        begin
            timeout_count++;
            $display("Timeout: no trap taken for the %s within %0d cycles", what, limit);
        end
        else
            check_value("flush", seen_flush, 1'b1);     // trap entry must flush
        @(posedge clk);
    endtask

    task automatic track_trap_entry(input logic [DATA_W-1:0] epc);
        prmd_exp = '0;
        prmd_exp[PLV_IE_HI:PLV_IE_LO] = crmd_exp[PLV_IE_HI:PLV_IE_LO];
        crmd_exp[PLV_IE_HI:PLV_IE_LO] = '0;
        era_exp = epc;
    endtask

    task automatic raise_exception(input ecode_t code, input logic [SUBCODE_W-1:0] sub,
                                   input logic [DATA_W-1:0] epc);
        @(posedge clk);
        excp_valid   <= 1'b1;
        excp_ecode   <= code;
        excp_subcode <= sub;
        pc           <= epc;
        @(posedge clk);
        excp_valid <= 1'b0;
        wait_trap(8, "pipeline exception");
    endtask

    task automatic return_from_trap();
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        issue_op(ERTN, CRMD, '0, '0, '0, 1'b0);
        while (!done && n < 8)
        begin
            @(negedge clk);
            n++;
            done = (ertn_flush === 1'b1);
        end
        if (!done)
        begin
            timeout_count++;
            $display("Timeout: ertn_flush never pulsed after ERTN");
        end
        @(posedge clk);
        crmd_exp[PLV_IE_HI:PLV_IE_LO] = prmd_exp[PLV_IE_HI:PLV_IE_LO];
        verify_crmd();
    endtask

    task automatic run_read_write();
        logic [CSR_NUM_W-1:0] num;
        logic [DATA_W-1:0]    wd;
        logic [DATA_W-1:0]    wm;
        for (int i = 0; i < 4; i++)
        begin
            num = SAVE0;
            num[1:0] = i[1:0];
            wd = $random(seed);
            write_csr(num, wd, save_exp[i]);
            save_exp[i] = ref_readback(num, wd);
        end
        wd = $random(seed);
        write_csr(TID, wd, tid_exp);
        tid_exp = ref_readback(TID, wd);
        wd = $random(seed);
        write_csr(EENTRY, wd, eentry_exp);
        eentry_exp = ref_readback(EENTRY, wd);
        for (int i = 0; i < 4; i++)
        begin
            num = SAVE0;
            num[1:0] = i[1:0];
            read_csr(num, save_exp[i]);
        end
        read_csr(TID, tid_exp);
        read_csr(EENTRY, eentry_exp);
        wd = $random(seed);
        wm = $random(seed);
        issue_op(CSRXCHG, SAVE1, wd, wm, save_exp[1], 1'b1);
        save_exp[1] = ref_merge(save_exp[1], wd, wm);
        read_csr(SAVE1, save_exp[1]);
        write_csr(14'h123, $random(seed), '0);     // no register at this number
        read_csr(14'h123, '0);
    endtask

    task automatic run_crmd_rule();
        logic [DATA_W-1:0] wd;
        for (int i = 0; i < 4; i++)
        begin
            wd = $random(seed);
            wd[DA_PG_HI:DA_PG_LO] = DA_PG_SEQ[2*i +: 2];
            write_csr(CRMD, wd, crmd_exp);
            crmd_exp = ref_crmd_write(crmd_exp, wd);
            verify_crmd();
            read_csr(CRMD, crmd_exp);
        end
        write_csr(CRMD, 32'h0000_000f, crmd_exp);  // PLV3, IE on, DA
        crmd_exp = ref_crmd_write(crmd_exp, 32'h0000_000f);
        verify_crmd();
    endtask

    task automatic run_exception();
        logic [DATA_W-1:0]    wd;
        logic [DATA_W-1:0]    epc;
        logic [SUBCODE_W-1:0] sub;
        wd = $random(seed);
        write_csr(EENTRY, wd, eentry_exp);
        eentry_exp = ref_readback(EENTRY, wd);
        epc = $random(seed);
        epc[1:0] = 2'b00;
        sub = $random(seed);
        raise_exception(SYS, sub, epc);
        track_trap_entry(epc);
        estat_exp = ref_estat(2'b00, 1'b0, SYS, sub);
        verify_crmd();
        read_csr(ERA, era_exp);
        read_csr(ESTAT, estat_exp);
        read_csr(PRMD, prmd_exp);
        return_from_trap();
    endtask

    task automatic run_interrupts();
        @(posedge clk);
        hw_int <= 8'h08;    // vector line 5
        expect_quiet(10);
        write_csr(ECFG, 32'h0000_0020, ecfg_exp);
        ecfg_exp = 32'h0000_0020;
        wait_trap(8, "hardware interrupt");
        track_trap_entry(last_pc);
        estat_exp = ref_estat(2'b00, 1'b0, INT, '0);
        verify_crmd();
        read_csr(ESTAT, estat_exp);
        @(posedge clk);
        hw_int <= '0;
        return_from_trap();

        write_csr(ECFG, '0, ecfg_exp);
        ecfg_exp = '0;
        write_csr(ESTAT, 32'h0000_0001, estat_exp);
        estat_exp = ref_estat(2'b01, 1'b0, INT, '0);
        expect_quiet(10);
        write_csr(ECFG, 32'h0000_0001, ecfg_exp);
        ecfg_exp = 32'h0000_0001;
        wait_trap(8, "software interrupt");
        track_trap_entry(last_pc);
        verify_crmd();
        read_csr(ESTAT, estat_exp);
        write_csr(ESTAT, '0, estat_exp);
        estat_exp = ref_estat(2'b00, 1'b0, INT, '0);
        return_from_trap();
    endtask

    task automatic run_timer();
        write_csr(ECFG, 32'h0000_0800, ecfg_exp);
        ecfg_exp = 32'h0000_0800;
        write_csr(TCFG, 32'h0000_0021, '0);    // enabled, one-shot, count 0x20
        wait_trap(120, "timer interrupt");
        track_trap_entry(last_pc);
        estat_exp = ref_estat(2'b00, 1'b1, INT, '0);
        verify_crmd();
        read_csr(ESTAT, estat_exp);
        write_csr(TICLR, 32'h0000_0001, '0);
        estat_exp = ref_estat(2'b00, 1'b0, INT, '0);
        read_csr(ESTAT, estat_exp);
        return_from_trap();
        expect_quiet(60);
    endtask

    initial
    begin
        seed          = 32'hd521;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        rstn         <= 1'b0;
        op_valid     <= 1'b0;
        op           <= NOP;
        csr_num      <= '0;
        wdata        <= '0;
        wmask        <= '0;
        pc           <= '0;
        excp_valid   <= 1'b0;
        excp_ecode   <= INT;
        excp_subcode <= '0;
        hw_int       <= '0;
        save_exp   = '{default: '0};
        tid_exp    = '0;
        eentry_exp = '0;
        ecfg_exp   = '0;
        crmd_exp   = 32'h0000_0008;
        prmd_exp   = '0;
        era_exp    = '0;
        estat_exp  = '0;
        last_pc    = '0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        expect_quiet(10);
        check_value("crmd", crmd, 32'h0000_0008);
        run_read_write();
        run_crmd_rule();
        run_exception();
        run_interrupts();
        run_timer();

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
